/* Makefile */
SRCS := $(wildcard common/*.sv hw/*.sv tb/*.sv)

obj_dir/Vtb_soc_bus: list.f $(SRCS)
	verilator --binary --timing --assert -f list.f --top-module tb_soc_bus -Mdir obj_dir

run: obj_dir/Vtb_soc_bus
	@out="$$(./obj_dir/Vtb_soc_bus)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

.PHONY: run clean

/* common/bus_pkg.sv */
package bus_pkg;

    // cpu side bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    // board side address widths
    localparam int SRAM_ADDR_W  = 20;
    localparam int FLASH_ADDR_W = 23;
    localparam int ROM_ADDR_W   = 12;

    // region field sits at address bits 29:28
    localparam int REGION_LSB = 28;

    localparam logic [1:0] REGION_SRAM   = 2'd0;
    localparam logic [1:0] REGION_FLASH  = 2'd1;
    localparam logic [1:0] REGION_SERIAL = 2'd2;
    localparam logic [1:0] REGION_ROM    = 2'd3;

    // serial register byte offsets
    localparam logic [3:0] SERIAL_STAT_OFS = 4'hc;
    localparam logic [3:0] SERIAL_DATA_OFS = 4'h8;

    // request source tag carried down the pipeline
    localparam logic SRC_FETCH = 1'b0;
    localparam logic SRC_DATA  = 1'b1;

    // word addressed sram view, bit 22 picks the extension bank
    typedef struct packed {
        logic [ADDR_W-SRAM_ADDR_W-4:0] upper;
        logic                          bank;
        logic [SRAM_ADDR_W-1:0]        word;
        logic [1:0]                    byte_ofs;
    } sram_view_t;

    // halfword addressed flash view
    typedef struct packed {
        logic [ADDR_W-FLASH_ADDR_W-2:0] upper;
        logic [FLASH_ADDR_W-1:0]        half;
        logic                           byte_ofs;
    } flash_view_t;

    // registered request address
    // rom word and serial offset come out of the sram view
    typedef union packed {
        sram_view_t          sram;
        flash_view_t         flash;
        logic [ADDR_W-1:0]   raw;
    } bus_addr_u;

endpackage

/* hw/bus_arbiter.sv */
`timescale 1ns/1ns

module bus_arbiter (
    input  logic                         clk_in,
    input  logic                         rst_n_i,
    // data memory port
    input  logic                         mem_req_i,
    input  logic                         mem_we_i,
    input  logic [bus_pkg::ADDR_W-1:0]   mem_addr_i,
    input  logic [bus_pkg::SEL_W-1:0]    mem_sel_i,
    input  logic [bus_pkg::DATA_W-1:0]   mem_wdata_i,
    // instruction fetch port
    input  logic                         if_req_i,
    input  logic [bus_pkg::ADDR_W-1:0]   if_addr_i,
    output logic                         if_stall_o,
    // stage 1 request register
    output logic                         req_valid_o,
    output logic                         req_src_o,
    output logic                         req_we_o,
    output logic [bus_pkg::SEL_W-1:0]    req_sel_o,
    output logic [bus_pkg::DATA_W-1:0]   req_wdata_o,
    output logic [1:0]                   req_region_o,
    output bus_pkg::bus_addr_u           req_addr_o
);

    import bus_pkg::*;

    logic                 pick_data;
    logic [ADDR_W-1:0]    pick_addr;
    logic [1:0]           pick_region;
    logic [SEL_W-1:0]     pick_sel;

    // data port always wins
    assign pick_data  = mem_req_i;
    assign if_stall_o = mem_req_i & if_req_i;

    assign pick_addr   = pick_data ? mem_addr_i : if_addr_i;
    assign pick_region = pick_addr[REGION_LSB+1:REGION_LSB];

    // a fetch is always a full word read
    assign pick_sel = pick_data ? mem_sel_i : {SEL_W{1'b1}};

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_valid_o <= 1'b0;
            req_src_o   <= SRC_FETCH;
            req_we_o    <= 1'b0;
        end else begin
            req_valid_o <= mem_req_i | if_req_i;
            req_src_o   <= pick_data ? SRC_DATA : SRC_FETCH;
            req_we_o    <= pick_data & mem_we_i;
        end
    end

    always_ff @(posedge clk_in) begin
        req_sel_o      <= pick_sel;
        req_wdata_o    <= mem_wdata_i;
        req_region_o   <= pick_region;
        req_addr_o.raw <= pick_addr;
    end

endmodule

/* hw/device_port.sv */
`timescale 1ns/1ns

module device_port (
    input  logic                              clk_in,
    input  logic                              rst_n_i,
    // stage 1 request
    input  logic                              req_valid_i,
    input  logic                              req_src_i,
    input  logic                              req_we_i,
    input  logic [bus_pkg::SEL_W-1:0]         req_sel_i,
    input  logic [bus_pkg::DATA_W-1:0]        req_wdata_i,
    input  logic [1:0]                        req_region_i,
    input  bus_pkg::bus_addr_u                req_addr_i,
    // read data sources
    input  logic [bus_pkg::DATA_W-1:0]        base_ram_data_i,
    input  logic [bus_pkg::DATA_W-1:0]        ext_ram_data_i,
    input  logic [15:0]                       flash_data_i,
    input  logic [bus_pkg::DATA_W-1:0]        rom_data_i,
    input  logic [bus_pkg::DATA_W-1:0]        serial_rdata_i,
    // sram pins
    output logic [bus_pkg::SRAM_ADDR_W-1:0]   base_ram_addr_o,
    output logic [bus_pkg::SEL_W-1:0]         base_ram_be_n_o,
    output logic                              base_ram_ce_n_o,
    output logic                              base_ram_oe_n_o,
    output logic                              base_ram_we_n_o,
    output logic [bus_pkg::SRAM_ADDR_W-1:0]   ext_ram_addr_o,
    output logic [bus_pkg::SEL_W-1:0]         ext_ram_be_n_o,
    output logic                              ext_ram_ce_n_o,
    output logic                              ext_ram_oe_n_o,
    output logic                              ext_ram_we_n_o,
    output logic [bus_pkg::DATA_W-1:0]        ram_wdata_o,
    output logic                              ram_data_oe_o,
    // flash pins
    output logic [bus_pkg::FLASH_ADDR_W-1:0]  flash_a_o,
    output logic                              flash_ce_n_o,
    output logic                              flash_oe_n_o,
    output logic                              flash_we_n_o,
    // boot rom
    output logic [bus_pkg::ROM_ADDR_W-1:0]    rom_addr_o,
    output logic                              rom_ce_o,
    // cpu responses
    output logic [bus_pkg::DATA_W-1:0]        mem_rdata_o,
    output logic                              mem_ack_o,
    output logic [bus_pkg::DATA_W-1:0]        if_rdata_o,
    output logic                              if_ack_o
);

    import bus_pkg::*;

    logic                 sram_sel;
    logic                 base_sel;
    logic                 ext_sel;
    logic                 flash_sel;
    logic                 rom_sel;
    logic [DATA_W-1:0]    rd_word;

    // stage 2 device select
    assign sram_sel  = req_valid_i && (req_region_i == REGION_SRAM);
    assign base_sel  = sram_sel && !req_addr_i.sram.bank;
    assign ext_sel   = sram_sel && req_addr_i.sram.bank;
    // flash and rom writes never reach the pins
    assign flash_sel = req_valid_i && (req_region_i == REGION_FLASH) && !req_we_i;
    assign rom_sel   = req_valid_i && (req_region_i == REGION_ROM) && !req_we_i;

    assign base_ram_addr_o = req_addr_i.sram.word;
    assign base_ram_be_n_o = ~req_sel_i;
    assign base_ram_ce_n_o = ~base_sel;
    assign base_ram_oe_n_o = ~(base_sel && !req_we_i);
    assign base_ram_we_n_o = ~(base_sel && req_we_i);

    assign ext_ram_addr_o = req_addr_i.sram.word;
    assign ext_ram_be_n_o = ~req_sel_i;
    assign ext_ram_ce_n_o = ~ext_sel;
    assign ext_ram_oe_n_o = ~(ext_sel && !req_we_i);
    assign ext_ram_we_n_o = ~(ext_sel && req_we_i);

    // both banks share one write data bus
    assign ram_wdata_o   = req_wdata_i;
    assign ram_data_oe_o = sram_sel && req_we_i;

    assign flash_a_o    = req_addr_i.flash.half;
    assign flash_ce_n_o = ~flash_sel;
    assign flash_oe_n_o = ~flash_sel;
    assign flash_we_n_o = 1'b1;

    assign rom_addr_o = req_addr_i.sram.word[ROM_ADDR_W-1:0];
    assign rom_ce_o   = rom_sel;

    always_comb begin
        rd_word = '0;
        if (!req_we_i) begin
            case (req_region_i)
                REGION_SRAM:   rd_word = req_addr_i.sram.bank ? ext_ram_data_i : base_ram_data_i;
                REGION_FLASH:  rd_word = {16'b0, flash_data_i};
                // fetches see zero from the serial block
                REGION_SERIAL: rd_word = (req_src_i == SRC_DATA) ? serial_rdata_i : '0;
                default:       rd_word = rom_data_i;
            endcase
        end
    end

    // stage 3 response, ack goes to the source port only
    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_ack_o <= 1'b0;
            if_ack_o  <= 1'b0;
        end else begin
            mem_ack_o <= req_valid_i && (req_src_i == SRC_DATA);
            if_ack_o  <= req_valid_i && (req_src_i == SRC_FETCH);
        end
    end

    always_ff @(posedge clk_in) begin
        if (req_valid_i && (req_src_i == SRC_DATA)) begin
            mem_rdata_o <= rd_word;
        end
        if (req_valid_i && (req_src_i == SRC_FETCH)) begin
            if_rdata_o <= rd_word;
        end
    end

endmodule

/* hw/serial_regs.sv */
`timescale 1ns/1ns

module serial_regs (
    input  logic                         clk_in,
    input  logic                         rst_n_i,
    input  logic                         req_valid_i,
    input  logic                         req_src_i,
    input  logic                         req_we_i,
    input  logic [1:0]                   req_region_i,
    input  bus_pkg::bus_addr_u           req_addr_i,
    input  logic [bus_pkg::DATA_W-1:0]   req_wdata_i,
    input  logic                         rx_valid_i,
    input  logic [7:0]                   rx_data_i,
    input  logic                         tx_busy_i,
    output logic [bus_pkg::DATA_W-1:0]   serial_rdata_o,
    output logic [7:0]                   tx_data_o,
    output logic                         tx_start_o,
    output logic                         rx_irq_o
);

    import bus_pkg::*;

    logic [3:0]    reg_ofs;
    logic          stat_hit;
    logic          data_hit;
    logic          rd_clear;
    logic          tx_go;
    logic          pending;
    logic [7:0]    rx_byte;

    assign reg_ofs  = {req_addr_i.sram.word[1:0], req_addr_i.sram.byte_ofs};
    assign stat_hit = req_valid_i && (req_region_i == REGION_SERIAL)
                      && (reg_ofs == SERIAL_STAT_OFS);
    assign data_hit = req_valid_i && (req_region_i == REGION_SERIAL)
                      && (reg_ofs == SERIAL_DATA_OFS);

    // only the data port may consume a byte or start a transmit
    assign rd_clear = data_hit && !req_we_i && (req_src_i == SRC_DATA);
    // busy writes are simply lost
    assign tx_go    = data_hit && req_we_i && (req_src_i == SRC_DATA) && !tx_busy_i;

    always_comb begin
        serial_rdata_o = '0;
        if (stat_hit) begin
            serial_rdata_o = {{(DATA_W-2){1'b0}}, pending, ~tx_busy_i};
        end else if (data_hit) begin
            serial_rdata_o = {{(DATA_W-8){1'b0}}, rx_byte};
        end
    end

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending    <= 1'b0;
            tx_start_o <= 1'b0;
        end else begin
            tx_start_o <= tx_go;
            // a new byte wins over a clearing read
            if (rx_valid_i) begin
                pending <= 1'b1;
            end else if (rd_clear) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rx_valid_i) begin
            rx_byte <= rx_data_i;
        end
        if (tx_go) begin
            tx_data_o <= req_wdata_i[7:0];
        end
    end

    assign rx_irq_o = pending;

endmodule

/* hw/soc_bus_top.sv */
`timescale 1ns/1ns

module soc_bus_top (
    input  logic                              clk_in,
    input  logic                              rst_n_i,
    // data memory port
    input  logic                              mem_req_i,
    input  logic                              mem_we_i,
    input  logic [bus_pkg::ADDR_W-1:0]        mem_addr_i,
    input  logic [bus_pkg::SEL_W-1:0]         mem_sel_i,
    input  logic [bus_pkg::DATA_W-1:0]        mem_wdata_i,
    output logic [bus_pkg::DATA_W-1:0]        mem_rdata_o,
    output logic                              mem_ack_o,
    // instruction fetch port
    input  logic                              if_req_i,
    input  logic [bus_pkg::ADDR_W-1:0]        if_addr_i,
    output logic [bus_pkg::DATA_W-1:0]        if_rdata_o,
    output logic                              if_ack_o,
    output logic                              if_stall_o,
    // sram banks
    input  logic [bus_pkg::DATA_W-1:0]        base_ram_data_i,
    output logic [bus_pkg::SRAM_ADDR_W-1:0]   base_ram_addr_o,
    output logic [bus_pkg::SEL_W-1:0]         base_ram_be_n_o,
    output logic                              base_ram_ce_n_o,
    output logic                              base_ram_oe_n_o,
    output logic                              base_ram_we_n_o,
    input  logic [bus_pkg::DATA_W-1:0]        ext_ram_data_i,
    output logic [bus_pkg::SRAM_ADDR_W-1:0]   ext_ram_addr_o,
    output logic [bus_pkg::SEL_W-1:0]         ext_ram_be_n_o,
    output logic                              ext_ram_ce_n_o,
    output logic                              ext_ram_oe_n_o,
    output logic                              ext_ram_we_n_o,
    output logic [bus_pkg::DATA_W-1:0]        ram_wdata_o,
    output logic                              ram_data_oe_o,
    // flash
    input  logic [15:0]                       flash_data_i,
    output logic [bus_pkg::FLASH_ADDR_W-1:0]  flash_a_o,
    output logic                              flash_ce_n_o,
    output logic                              flash_oe_n_o,
    output logic                              flash_we_n_o,
    // boot rom
    input  logic [bus_pkg::DATA_W-1:0]        rom_data_i,
    output logic [bus_pkg::ROM_ADDR_W-1:0]    rom_addr_o,
    output logic                              rom_ce_o,
    // serial port
    input  logic                              rx_valid_i,
    input  logic [7:0]                        rx_data_i,
    input  logic                              tx_busy_i,
    output logic [7:0]                        tx_data_o,
    output logic                              tx_start_o,
    output logic                              rx_irq_o
);

    import bus_pkg::*;

    // stage 1 request fields
    logic                 req_valid;
    logic                 req_src;
    logic                 req_we;
    logic [SEL_W-1:0]     req_sel;
    logic [DATA_W-1:0]    req_wdata;
    logic [1:0]           req_region;
    bus_addr_u            req_addr;
    logic [DATA_W-1:0]    serial_rdata;

    bus_arbiter u_arbiter (
        .clk_in       (clk_in),
        .rst_n_i      (rst_n_i),
        .mem_req_i    (mem_req_i),
        .mem_we_i     (mem_we_i),
        .mem_addr_i   (mem_addr_i),
        .mem_sel_i    (mem_sel_i),
        .mem_wdata_i  (mem_wdata_i),
        .if_req_i     (if_req_i),
        .if_addr_i    (if_addr_i),
        .if_stall_o   (if_stall_o),
        .req_valid_o  (req_valid),
        .req_src_o    (req_src),
        .req_we_o     (req_we),
        .req_sel_o    (req_sel),
        .req_wdata_o  (req_wdata),
        .req_region_o (req_region),
        .req_addr_o   (req_addr)
    );

    device_port u_device (
        .clk_in          (clk_in),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_valid),
        .req_src_i       (req_src),
        .req_we_i        (req_we),
        .req_sel_i       (req_sel),
        .req_wdata_i     (req_wdata),
        .req_region_i    (req_region),
        .req_addr_i      (req_addr),
        .base_ram_data_i (base_ram_data_i),
        .ext_ram_data_i  (ext_ram_data_i),
        .flash_data_i    (flash_data_i),
        .rom_data_i      (rom_data_i),
        .serial_rdata_i  (serial_rdata),
        .base_ram_addr_o (base_ram_addr_o),
        .base_ram_be_n_o (base_ram_be_n_o),
        .base_ram_ce_n_o (base_ram_ce_n_o),
        .base_ram_oe_n_o (base_ram_oe_n_o),
        .base_ram_we_n_o (base_ram_we_n_o),
        .ext_ram_addr_o  (ext_ram_addr_o),
        .ext_ram_be_n_o  (ext_ram_be_n_o),
        .ext_ram_ce_n_o  (ext_ram_ce_n_o),
        .ext_ram_oe_n_o  (ext_ram_oe_n_o),
        .ext_ram_we_n_o  (ext_ram_we_n_o),
        .ram_wdata_o     (ram_wdata_o),
        .ram_data_oe_o   (ram_data_oe_o),
        .flash_a_o       (flash_a_o),
        .flash_ce_n_o    (flash_ce_n_o),
        .flash_oe_n_o    (flash_oe_n_o),
        .flash_we_n_o    (flash_we_n_o),
        .rom_addr_o      (rom_addr_o),
        .rom_ce_o        (rom_ce_o),
        .mem_rdata_o     (mem_rdata_o),
        .mem_ack_o       (mem_ack_o),
        .if_rdata_o      (if_rdata_o),
        .if_ack_o        (if_ack_o)
    );

    serial_regs u_serial (
        .clk_in         (clk_in),
        .rst_n_i        (rst_n_i),
        .req_valid_i    (req_valid),
        .req_src_i      (req_src),
        .req_we_i       (req_we),
        .req_region_i   (req_region),
        .req_addr_i     (req_addr),
        .req_wdata_i    (req_wdata),
        .rx_valid_i     (rx_valid_i),
        .rx_data_i      (rx_data_i),
        .tx_busy_i      (tx_busy_i),
        .serial_rdata_o (serial_rdata),
        .tx_data_o      (tx_data_o),
        .tx_start_o     (tx_start_o),
        .rx_irq_o       (rx_irq_o)
    );

endmodule

/* list.f */
common/bus_pkg.sv
hw/bus_arbiter.sv
hw/device_port.sv
hw/serial_regs.sv
hw/soc_bus_top.sv
tb/tb_soc_bus.sv

/* tb/bus_testdata.txt */
# port (0 fetch, 1 data, 2 data and fetch together) we addr sel wdata busy rx_valid rx_byte
# then exp_rdata exp_tx exp_irq, all hex; exp_rdata is ignored for writes
1 1 00000010 f 11223344 0 0 00 00000000 0 0
1 1 00400010 f 55667788 0 0 00 00000000 0 0
1 1 00000010 3 aaaabbbb 0 0 00 00000000 0 0
1 1 00400010 c ccccdddd 0 0 00 00000000 0 0
1 0 00000010 f 00000000 0 0 00 1122bbbb 0 0
1 0 00400010 f 00000000 0 0 00 cccc7788 0 0
1 1 00000020 5 01020304 0 0 00 00000000 0 0
1 0 00000020 f 00000000 0 0 00 00020004 0 0
1 0 00400020 f 00000000 0 0 00 00000000 0 0
0 0 00000010 f 00000000 0 0 00 1122bbbb 0 0
0 0 30000040 f 00000000 0 0 00 b0070010 0 0
2 0 00400010 f 00000000 0 0 00 cccc7788 0 0
2 0 30000008 f 00000000 0 0 00 b0070002 0 0
1 0 10000010 f 00000000 0 0 00 0000a008 0 0
1 0 10000022 f 00000000 0 0 00 0000a011 0 0
0 0 10000004 f 00000000 0 0 00 0000a002 0 0
1 1 10000010 f ffffffff 0 0 00 00000000 0 0
1 0 10000010 f 00000000 0 0 00 0000a008 0 0
1 1 30000040 f deadbeef 0 0 00 00000000 0 0
1 0 30000040 f 00000000 0 0 00 b0070010 0 0
1 0 2000000c f 00000000 0 0 00 00000001 0 0
1 0 2000000c f 00000000 0 1 5a 00000003 0 1
1 0 20000008 f 00000000 0 0 00 0000005a 0 0
1 0 2000000c f 00000000 0 0 00 00000001 0 0
1 1 20000008 f 00000041 0 0 00 00000000 1 0
1 1 20000008 f 00000042 1 0 00 00000000 0 0
1 0 2000000c f 00000000 1 0 00 00000000 0 0
0 0 20000008 f 00000000 0 1 7e 00000000 0 1
1 0 2000000c f 00000000 0 0 00 00000003 0 1
1 0 20000008 f 00000000 0 0 00 0000007e 0 0

/* tb/tb_soc_bus.sv */
`timescale 1ns/1ns

module tb_soc_bus;

    import bus_pkg::*;

    localparam int RESET_CYCLES = 10;

    logic                     clk_in;
    logic                     rst_n_i;
    logic                     mem_req_i;
    logic                     mem_we_i;
    logic [ADDR_W-1:0]        mem_addr_i;
    logic [SEL_W-1:0]         mem_sel_i;
    logic [DATA_W-1:0]        mem_wdata_i;
    logic [DATA_W-1:0]        mem_rdata_o;
    logic                     mem_ack_o;
    logic                     if_req_i;
    logic [ADDR_W-1:0]        if_addr_i;
    logic [DATA_W-1:0]        if_rdata_o;
    logic                     if_ack_o;
    logic                     if_stall_o;
    logic [DATA_W-1:0]        base_ram_data_i;
    logic [SRAM_ADDR_W-1:0]   base_ram_addr_o;
    logic [SEL_W-1:0]         base_ram_be_n_o;
    logic                     base_ram_ce_n_o;
    logic                     base_ram_oe_n_o;
    logic                     base_ram_we_n_o;
    logic [DATA_W-1:0]        ext_ram_data_i;
    logic [SRAM_ADDR_W-1:0]   ext_ram_addr_o;
    logic [SEL_W-1:0]         ext_ram_be_n_o;
    logic                     ext_ram_ce_n_o;
    logic                     ext_ram_oe_n_o;
    logic                     ext_ram_we_n_o;
    logic [DATA_W-1:0]        ram_wdata_o;
    logic                     ram_data_oe_o;
    logic [15:0]              flash_data_i;
    logic [FLASH_ADDR_W-1:0]  flash_a_o;
    logic                     flash_ce_n_o;
    logic                     flash_oe_n_o;
    logic                     flash_we_n_o;
    logic [DATA_W-1:0]        rom_data_i;
    logic [ROM_ADDR_W-1:0]    rom_addr_o;
    logic                     rom_ce_o;
    logic                     rx_valid_i;
    logic [7:0]               rx_data_i;
    logic                     tx_busy_i;
    logic [7:0]               tx_data_o;
    logic                     tx_start_o;
    logic                     rx_irq_o;

    // device models
    logic [31:0]  base_mem  [0:1023];
    logic [31:0]  ext_mem   [0:1023];
    logic [15:0]  flash_mem [0:4095];
    logic [31:0]  rom_mem   [0:4095];

    string        vec_lines [$];
    int           cycle_cnt = 0;
    int           cycle_limit = 0;
    logic [7:0]   last_tx;
    logic         tx_seen = 1'b0;

    soc_bus_top DUT (.*);

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("TEST FAIL");
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $fatal(1);
        end
    endtask

    task automatic require_true(input logic cond, input string what);
        assert (cond) else begin
            $display("TEST FAIL");
            $display("at %0t ns: %s", $time, what);
            $fatal(1);
        end
    endtask

    // asynchronous sram, read while selected and output enabled
    assign base_ram_data_i = (!base_ram_ce_n_o && !base_ram_oe_n_o) ?
                             base_mem[base_ram_addr_o[9:0]] : '0;
    assign ext_ram_data_i  = (!ext_ram_ce_n_o && !ext_ram_oe_n_o) ?
                             ext_mem[ext_ram_addr_o[9:0]] : '0;
    assign flash_data_i    = (!flash_ce_n_o && !flash_oe_n_o) ? flash_mem[flash_a_o[11:0]] : '0;
    assign rom_data_i      = rom_ce_o ? rom_mem[rom_addr_o] : '0;

    // writes land mid cycle while the strobe is low
    always @(negedge clk_in) begin
        for (int b = 0; b < 4; b++) begin
            if (!base_ram_ce_n_o && !base_ram_we_n_o && !base_ram_be_n_o[b]) begin
                base_mem[base_ram_addr_o[9:0]][8*b +: 8] = ram_wdata_o[8*b +: 8];
            end
            if (!ext_ram_ce_n_o && !ext_ram_we_n_o && !ext_ram_be_n_o[b]) begin
                ext_mem[ext_ram_addr_o[9:0]][8*b +: 8] = ram_wdata_o[8*b +: 8];
            end
        end
        require_true((base_ram_we_n_o && ext_ram_we_n_o) || ram_data_oe_o,
                     "sram written without the data output enable");
        require_true(flash_we_n_o !== 1'b0, "write strobe reached the read-only flash");
        require_true($countones({!base_ram_ce_n_o, !ext_ram_ce_n_o, !flash_ce_n_o,
                                 rom_ce_o}) <= 1, "more than one device enabled");
    end

    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("TEST FAIL");
            $display("timeout after %0d cycles with vectors still pending", cycle_cnt);
            $fatal(1);
        end
    end

    // one vector line: optional rx byte, one request, wait for its acks
    task automatic run_vector(input string line);
        logic [1:0]   port;
        logic         we;
        logic [31:0]  addr;
        logic [3:0]   sel;
        logic [31:0]  wdata;
        logic         busy;
        logic         rxv;
        logic [7:0]   rxd;
        logic [31:0]  exp_rdata;
        logic         exp_tx;
        logic         exp_irq;
        int           fields;
        int           pulses;
        logic         got_mem;
        logic         got_if;

        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", port, we, addr, sel,
                         wdata, busy, rxv, rxd, exp_rdata, exp_tx, exp_irq);
        require_true(fields == 11, "malformed line in the vector file");
        pulses  = 0;
        got_mem = (port == 2'd0);
        got_if  = (port == 2'd1);
        if (rxv) begin
            @(posedge clk_in);
            rx_valid_i <= 1'b1;
            rx_data_i  <= rxd;
        end
        @(posedge clk_in);
        rx_valid_i  <= 1'b0;
        tx_busy_i   <= busy;
        mem_req_i   <= (port != 2'd0);
        mem_we_i    <= we;
        mem_addr_i  <= addr;
        mem_sel_i   <= sel;
        mem_wdata_i <= wdata;
        if_req_i    <= (port != 2'd1);
        if_addr_i   <= addr;
        @(negedge clk_in);
        compare_word("if_stall_o", {31'b0, if_stall_o}, {31'b0, port == 2'd2});
        // a stalled fetch is held one more cycle
        @(posedge clk_in);
        mem_req_i <= 1'b0;
        if (port != 2'd2) begin
            if_req_i <= 1'b0;
        end
        @(posedge clk_in);
        if_req_i <= 1'b0;
        while (!(got_mem && got_if)) begin
            @(negedge clk_in);
            if (tx_start_o) begin
                pulses++;
            end
            if (if_ack_o) begin
                require_true(!got_if, "unexpected ack on the fetch port");
                require_true(got_mem, "fetch ack arrived before the data ack");
                compare_word("if_rdata_o", if_rdata_o, exp_rdata);
                got_if = 1'b1;
            end
            if (mem_ack_o) begin
                require_true(!got_mem, "unexpected ack on the data port");
                if (!we) begin
                    compare_word("mem_rdata_o", mem_rdata_o, exp_rdata);
                end
                got_mem = 1'b1;
            end
        end
        compare_word("tx_start_o pulse count", 32'(pulses), {31'b0, exp_tx});
        if (exp_tx) begin
            last_tx = wdata[7:0];
            tx_seen = 1'b1;
        end
        if (tx_seen) begin
            compare_word("tx_data_o", {24'b0, tx_data_o}, {24'b0, last_tx});
        end
        compare_word("rx_irq_o", {31'b0, rx_irq_o}, {31'b0, exp_irq});
    endtask

    initial begin
        int     fd;
        string  line;

        rst_n_i     <= 1'b0;
        mem_req_i   <= 1'b0;
        mem_we_i    <= 1'b0;
        mem_addr_i  <= '0;
        mem_sel_i   <= '0;
        mem_wdata_i <= '0;
        if_req_i    <= 1'b0;
        if_addr_i   <= '0;
        rx_valid_i  <= 1'b0;
        rx_data_i   <= '0;
        tx_busy_i   <= 1'b0;
        for (int i = 0; i < 4096; i++) begin
            flash_mem[i] = 16'ha000 | 16'(i);
            rom_mem[i]   = 32'hb0070000 | 32'(i);
        end
        for (int i = 0; i < 1024; i++) begin
            base_mem[i] = '0;
            ext_mem[i]  = '0;
        end
        fd = $fopen("tb/bus_testdata.txt", "r");
        require_true(fd != 0, "cannot open the vector file tb/bus_testdata.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                vec_lines.push_back(line);
            end
        end
        $fclose(fd);
        cycle_limit = 8 * vec_lines.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_n_i <= 1'b1;
        foreach (vec_lines[i]) begin
            run_vector(vec_lines[i]);
        end
        repeat (2) @(posedge clk_in);
        $display("TEST PASS");
        $finish;
    end

endmodule
